// File: fetch_pkg.sv
package fetch_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // widths and sizes.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int xlen        = 32;
    localparam int bundle_w    = 64;
    localparam int imem_addr_w = 8;
    localparam int buf_depth   = 2;

    // first fetch address after reset.
    localparam logic [xlen-1:0] pc_reset = 32'h0000_0000;

    // andi r0, r0, 0.
    localparam logic [xlen-1:0] inst_nop = 32'h0340_0000;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // encodings.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // exception code, same width as the back end expects.
    typedef enum logic [6:0] {
        excp_none = 7'h00,
        excp_adef = 7'h08
    } excp_e;

    // pc generator states.
    typedef enum logic [1:0] {
        fs_idle = 2'd0,
        fs_req  = 2'd1,
        fs_wait = 2'd2
    } fetch_state_e;

endpackage

// File: inst_mem.sv
`timescale 1ns/100ps

module inst_mem #(
    parameter int imem_addr_w = fetch_pkg::imem_addr_w
) (
    input  logic                            clk,
    input  logic                            mem_en,
    input  logic                            mem_we,
    input  logic [imem_addr_w-1:0]          mem_addr,
    input  logic [fetch_pkg::xlen-1:0]      mem_wdata,
    output logic [fetch_pkg::bundle_w-1:0]  mem_rdata
);
    import fetch_pkg::*;

    localparam int words = 1 << imem_addr_w;

    logic [xlen-1:0]        mem_q [words];
    logic [imem_addr_w-1:0] addr_hi;

    // second word of the pair, wraps at the top of the array.
    assign addr_hi = mem_addr + 1'b1;

    // one port, a write wins the cycle; reads land one cycle later.
    always_ff @(posedge clk) begin
        if (mem_en) begin
            if (mem_we) begin
                mem_q[mem_addr] <= mem_wdata;
            end else begin
                mem_rdata <= {mem_q[addr_hi], mem_q[mem_addr]};
            end
        end
    end

endmodule

// File: imem_arbiter.sv
`timescale 1ns/100ps

module imem_arbiter #(
    parameter int imem_addr_w = fetch_pkg::imem_addr_w
) (
    input  logic                        clk,
    input  logic                        arst_n,
    // loader side.
    input  logic                        ld_we,
    input  logic [imem_addr_w-1:0]      ld_addr,
    input  logic [fetch_pkg::xlen-1:0]  ld_wdata,
    output logic                        ld_busy,
    // fetch side.
    input  logic                        if_req,
    input  logic [imem_addr_w-1:0]      if_addr,
    output logic                        if_gnt,
    // memory side.
    output logic                        mem_en,
    output logic                        mem_we,
    output logic [imem_addr_w-1:0]      mem_addr,
    output logic [fetch_pkg::xlen-1:0]  mem_wdata
);

    // {loader, fetch}.
    logic [1:0] gnt_now;

    // loader first, fetch takes the port only in a quiet cycle.
    assign ld_busy = ld_we;
    assign if_gnt  = if_req && !ld_we;
    assign gnt_now = {ld_busy, if_gnt};

    assign mem_en    = |gnt_now;
    assign mem_we    = ld_busy;
    assign mem_addr  = ld_busy ? ld_addr : if_addr;
    assign mem_wdata = ld_wdata;

    // a write strobe carries a known address and data.
    a_ld_known: assert property (
        @(posedge clk) disable iff (!arst_n) ld_we |-> !$isunknown({ld_addr, ld_wdata})
    ) else $error("loader write with unknown address or data");

endmodule

// File: fetch_pc_gen.sv
`timescale 1ns/100ps

module fetch_pc_gen #(
    parameter int imem_addr_w = fetch_pkg::imem_addr_w
) (
    input  logic                            clk,
    input  logic                            arst_n,
    input  logic                            redirect,
    input  logic [fetch_pkg::xlen-1:0]      redirect_pc,
    output logic                            if_req,
    output logic [imem_addr_w-1:0]          if_addr,
    input  logic                            if_gnt,
    input  logic [fetch_pkg::bundle_w-1:0]  mem_rdata,
    input  logic                            fifo_allowin,
    output logic                            fifo_readygo,
    output logic [fetch_pkg::xlen-1:0]      if1_fifo_inst0,
    output logic [fetch_pkg::xlen-1:0]      if1_fifo_inst1,
    output logic [fetch_pkg::xlen-1:0]      if1_fifo_pc,
    output logic [fetch_pkg::xlen-1:0]      if1_fifo_pc_next,
    output fetch_pkg::excp_e                if1_fifo_exception
);
    import fetch_pkg::*;

    fetch_state_e    state_q;
    fetch_state_e    state_d;
    logic [xlen-1:0] pc_q;
    logic            misaligned;

    assign misaligned = |pc_q[1:0];

    // no request while the buffer has no free entry.
    assign if_req  = (state_q == fs_req) && fifo_allowin;
    assign if_addr = pc_q[imem_addr_w+1:2];

    // read data is valid in fs_wait, a redirect drops it.
    assign fifo_readygo = (state_q == fs_wait) && !redirect;

    assign if1_fifo_pc        = pc_q;
    assign if1_fifo_pc_next   = pc_q + xlen'(8);
    assign if1_fifo_inst0     = misaligned ? inst_nop : mem_rdata[xlen-1:0];
    assign if1_fifo_inst1     = misaligned ? inst_nop : mem_rdata[bundle_w-1:xlen];
    assign if1_fifo_exception = misaligned ? excp_adef : excp_none;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // fetch FSM.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        state_d = state_q;
        if (redirect) begin
            // a bad target skips the read and reports straight from fs_wait.
            state_d = (|redirect_pc[1:0]) ? fs_wait : fs_req;
        end else begin
            case (state_q)
                // stays parked here after an address fault.
                fs_idle: state_d = misaligned ? fs_idle : fs_req;
                fs_req:  state_d = if_gnt ? fs_wait : fs_req;
                fs_wait: state_d = misaligned ? fs_idle : fs_req;
                default: state_d = fs_idle;
            endcase
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q <= fs_idle;
            pc_q    <= pc_reset;
        end else begin
            state_q <= state_d;
            if (redirect) begin
                pc_q <= redirect_pc;
            end else if (fifo_readygo) begin
                pc_q <= pc_q + xlen'(8);
            end
        end
    end

endmodule

// File: fetch_buf_fifo.sv
`timescale 1ns/100ps

module fetch_buf_fifo #(
    parameter int data_width = 64,
    parameter int depth      = 2
) (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  flush,
    input  logic                  write_en,
    input  logic                  pop_en,
    input  logic [data_width-1:0] din,
    output logic [data_width-1:0] dout,
    output logic                  full,
    output logic                  empty
);

    localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
    localparam int cnt_w = $clog2(depth + 1);

    logic [data_width-1:0] mem_q [depth];
    logic [ptr_w-1:0]      wr_ptr;
    logic [ptr_w-1:0]      rd_ptr;
    logic [cnt_w-1:0]      count;
    logic                  do_wr;
    logic                  do_pop;

    // pointers wrap at depth, so depth need not be a power of two.
    function automatic logic [ptr_w-1:0] ptr_inc(input logic [ptr_w-1:0] ptr);
        return (ptr == ptr_w'(depth - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign full   = (count == cnt_w'(depth));
    assign empty  = (count == '0);
    assign do_wr  = write_en && !full;
    assign do_pop = pop_en && !empty;
    assign dout   = mem_q[rd_ptr];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            count <= count + cnt_w'(do_wr) - cnt_w'(do_pop);
        end
    end

    // storage.
    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem_q[wr_ptr] <= din;
        end
    end

    a_no_overflow: assert property (
        @(posedge clk) disable iff (!arst_n) (write_en && !flush) |-> !full
    ) else $error("fifo write while full");

    a_no_underflow: assert property (
        @(posedge clk) disable iff (!arst_n) (pop_en && !flush) |-> !empty
    ) else $error("fifo pop while empty");

endmodule

// File: fetch_buffer.sv
`timescale 1ns/100ps

module fetch_buffer #(
    parameter int buf_depth = fetch_pkg::buf_depth
) (
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic                        flush,
    // handshake.
    input  logic                        fifo_readygo,
    output logic                        fifo_allowin,
    input  logic                        fifo_ready,
    output logic                        fifo_valid,
    // bundle from the pc generator.
    input  logic [fetch_pkg::xlen-1:0]  if1_fifo_inst0,
    input  logic [fetch_pkg::xlen-1:0]  if1_fifo_inst1,
    input  logic [fetch_pkg::xlen-1:0]  if1_fifo_pc,
    input  logic [fetch_pkg::xlen-1:0]  if1_fifo_pc_next,
    input  fetch_pkg::excp_e            if1_fifo_exception,
    // head of the buffer, to decode.
    output logic [fetch_pkg::xlen-1:0]  fifo_inst0,
    output logic [fetch_pkg::xlen-1:0]  fifo_inst1,
    output logic [fetch_pkg::xlen-1:0]  fifo_pc,
    output logic [fetch_pkg::xlen-1:0]  fifo_pc_add,
    output logic [fetch_pkg::xlen-1:0]  fifo_pc_next,
    output fetch_pkg::excp_e            fifo_exception
);
    import fetch_pkg::*;

    localparam int st_w = $bits(excp_e);

    logic                write_en;
    logic                pop_en;
    logic                inst_full;
    logic                inst_empty;
    logic [bundle_w-1:0] inst_din;
    logic [bundle_w-1:0] inst_dout;
    logic [2*xlen-1:0]   pc_din;
    logic [2*xlen-1:0]   pc_dout;
    logic [st_w-1:0]     st_din;
    logic [st_w-1:0]     st_dout;

    // the instruction lane speaks for all three.
    assign fifo_valid   = !inst_empty;
    assign fifo_allowin = !inst_full;
    assign write_en     = fifo_readygo && fifo_allowin;
    assign pop_en       = fifo_ready && fifo_valid;

    assign inst_din = {if1_fifo_inst1, if1_fifo_inst0};
    assign pc_din   = {if1_fifo_pc_next, if1_fifo_pc};
    assign st_din   = if1_fifo_exception;

    // nop bundle at the reset pc while nothing is held.
    always_comb begin
        if (fifo_valid) begin
            fifo_inst0     = inst_dout[xlen-1:0];
            fifo_inst1     = inst_dout[bundle_w-1:xlen];
            fifo_pc        = pc_dout[xlen-1:0];
            fifo_pc_next   = pc_dout[2*xlen-1:xlen];
            fifo_exception = excp_e'(st_dout);
        end else begin
            fifo_inst0     = inst_nop;
            fifo_inst1     = inst_nop;
            fifo_pc        = pc_reset;
            fifo_pc_next   = pc_reset + xlen'(8);
            fifo_exception = excp_none;
        end
    end

    // pc of inst1.
    assign fifo_pc_add = fifo_pc + xlen'(4);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // lanes, sharing one write and one pop.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    fetch_buf_fifo #(.data_width(bundle_w), .depth(buf_depth)) i_inst_lane (
        .clk      (clk),
        .arst_n   (arst_n),
        .flush    (flush),
        .write_en (write_en),
        .pop_en   (pop_en),
        .din      (inst_din),
        .dout     (inst_dout),
        .full     (inst_full),
        .empty    (inst_empty)
    );

    fetch_buf_fifo #(.data_width(2 * xlen), .depth(buf_depth)) i_pc_lane (
        .clk      (clk),
        .arst_n   (arst_n),
        .flush    (flush),
        .write_en (write_en),
        .pop_en   (pop_en),
        .din      (pc_din),
        .dout     (pc_dout),
        .full     (),
        .empty    ()
    );

    fetch_buf_fifo #(.data_width(st_w), .depth(buf_depth)) i_stat_lane (
        .clk      (clk),
        .arst_n   (arst_n),
        .flush    (flush),
        .write_en (write_en),
        .pop_en   (pop_en),
        .din      (st_din),
        .dout     (st_dout),
        .full     (),
        .empty    ()
    );

    // fetch must wait for allowin before it pushes.
    a_push_when_full: assert property (
        @(posedge clk) disable iff (!arst_n) fifo_readygo |-> fifo_allowin
    ) else $error("bundle pushed into a full fetch buffer, dropped");

endmodule

// File: fetch_frontend_top.sv
`timescale 1ns/100ps

module fetch_frontend_top #(
    parameter int imem_addr_w = fetch_pkg::imem_addr_w,
    parameter int buf_depth   = fetch_pkg::buf_depth
) (
    input  logic                        clk,
    input  logic                        arst_n,
    // program loader.
    input  logic                        ld_we,
    input  logic [imem_addr_w-1:0]      ld_addr,
    input  logic [fetch_pkg::xlen-1:0]  ld_wdata,
    output logic                        ld_busy,
    // redirect from the back end.
    input  logic                        redirect,
    input  logic [fetch_pkg::xlen-1:0]  redirect_pc,
    // decode side.
    input  logic                        fifo_ready,
    output logic                        fifo_valid,
    output logic [fetch_pkg::xlen-1:0]  fifo_inst0,
    output logic [fetch_pkg::xlen-1:0]  fifo_inst1,
    output logic [fetch_pkg::xlen-1:0]  fifo_pc,
    output logic [fetch_pkg::xlen-1:0]  fifo_pc_add,
    output logic [fetch_pkg::xlen-1:0]  fifo_pc_next,
    output fetch_pkg::excp_e            fifo_exception
);
    import fetch_pkg::*;

    logic                   if_req;
    logic                   if_gnt;
    logic [imem_addr_w-1:0] if_addr;
    logic                   mem_en;
    logic                   mem_we;
    logic [imem_addr_w-1:0] mem_addr;
    logic [xlen-1:0]        mem_wdata;
    logic [bundle_w-1:0]    mem_rdata;
    logic                   fifo_readygo;
    logic                   fifo_allowin;
    logic [xlen-1:0]        if1_fifo_inst0;
    logic [xlen-1:0]        if1_fifo_inst1;
    logic [xlen-1:0]        if1_fifo_pc;
    logic [xlen-1:0]        if1_fifo_pc_next;
    excp_e                  if1_fifo_exception;

    inst_mem #(.imem_addr_w(imem_addr_w)) i_inst_mem (
        .clk       (clk),
        .mem_en    (mem_en),
        .mem_we    (mem_we),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_rdata (mem_rdata)
    );

    imem_arbiter #(.imem_addr_w(imem_addr_w)) i_imem_arbiter (
        .clk       (clk),
        .arst_n    (arst_n),
        .ld_we     (ld_we),
        .ld_addr   (ld_addr),
        .ld_wdata  (ld_wdata),
        .ld_busy   (ld_busy),
        .if_req    (if_req),
        .if_addr   (if_addr),
        .if_gnt    (if_gnt),
        .mem_en    (mem_en),
        .mem_we    (mem_we),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata)
    );

    fetch_pc_gen #(.imem_addr_w(imem_addr_w)) i_fetch_pc_gen (
        .clk                (clk),
        .arst_n             (arst_n),
        .redirect           (redirect),
        .redirect_pc        (redirect_pc),
        .if_req             (if_req),
        .if_addr            (if_addr),
        .if_gnt             (if_gnt),
        .mem_rdata          (mem_rdata),
        .fifo_allowin       (fifo_allowin),
        .fifo_readygo       (fifo_readygo),
        .if1_fifo_inst0     (if1_fifo_inst0),
        .if1_fifo_inst1     (if1_fifo_inst1),
        .if1_fifo_pc        (if1_fifo_pc),
        .if1_fifo_pc_next   (if1_fifo_pc_next),
        .if1_fifo_exception (if1_fifo_exception)
    );

    // a redirect also empties the buffer.
    fetch_buffer #(.buf_depth(buf_depth)) i_fetch_buffer (
        .clk                (clk),
        .arst_n             (arst_n),
        .flush              (redirect),
        .fifo_readygo       (fifo_readygo),
        .fifo_allowin       (fifo_allowin),
        .fifo_ready         (fifo_ready),
        .fifo_valid         (fifo_valid),
        .if1_fifo_inst0     (if1_fifo_inst0),
        .if1_fifo_inst1     (if1_fifo_inst1),
        .if1_fifo_pc        (if1_fifo_pc),
        .if1_fifo_pc_next   (if1_fifo_pc_next),
        .if1_fifo_exception (if1_fifo_exception),
        .fifo_inst0         (fifo_inst0),
        .fifo_inst1         (fifo_inst1),
        .fifo_pc            (fifo_pc),
        .fifo_pc_add        (fifo_pc_add),
        .fifo_pc_next       (fifo_pc_next),
        .fifo_exception     (fifo_exception)
    );

endmodule

// File: tb_clk_gen.sv
`timescale 1ns/100ps

module tb_clk_gen #(
    parameter int period_ns    = 20,
    parameter int reset_cycles = 5
) (
    output logic clk,
    output logic arst_n
);

    initial begin
        clk = 1'b0;
        forever begin
            #(period_ns / 2) clk = ~clk;
        end
    end

    // reset lets go a little after a rising edge.
    initial begin
        arst_n = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        #2 arst_n = 1'b1;
    end

endmodule

// File: tb_fetch_frontend.sv
`timescale 1ns/100ps

module tb_fetch_frontend;
    import fetch_pkg::*;

    localparam int mem_words  = 1 << imem_addr_w;
    // roughly four times the cycles the whole sequence needs.
    localparam int max_cycles = 20000;

    logic                   clk;
    logic                   arst_n;
    logic                   ld_we;
    logic [imem_addr_w-1:0] ld_addr;
    logic [xlen-1:0]        ld_wdata;
    logic                   ld_busy;
    logic                   redirect;
    logic [xlen-1:0]        redirect_pc;
    logic                   fifo_ready;
    logic                   fifo_valid;
    logic [xlen-1:0]        fifo_inst0;
    logic [xlen-1:0]        fifo_inst1;
    logic [xlen-1:0]        fifo_pc;
    logic [xlen-1:0]        fifo_pc_add;
    logic [xlen-1:0]        fifo_pc_next;
    excp_e                  fifo_exception;

    // reference model, a shadow of the memory and the next expected pc.
    logic [xlen-1:0] shadow [mem_words];
    logic [xlen-1:0] exp_pc;
    logic            model_on;
    int              pop_count;
    int              cycles = 0;

    tb_clk_gen #(.period_ns(20), .reset_cycles(5)) i_tb_clk_gen (
        .clk    (clk),
        .arst_n (arst_n)
    );

    fetch_frontend_top #(.imem_addr_w(imem_addr_w), .buf_depth(buf_depth)) i_fetch_frontend_top (
        .clk            (clk),
        .arst_n         (arst_n),
        .ld_we          (ld_we),
        .ld_addr        (ld_addr),
        .ld_wdata       (ld_wdata),
        .ld_busy        (ld_busy),
        .redirect       (redirect),
        .redirect_pc    (redirect_pc),
        .fifo_ready     (fifo_ready),
        .fifo_valid     (fifo_valid),
        .fifo_inst0     (fifo_inst0),
        .fifo_inst1     (fifo_inst1),
        .fifo_pc        (fifo_pc),
        .fifo_pc_add    (fifo_pc_add),
        .fifo_pc_next   (fifo_pc_next),
        .fifo_exception (fifo_exception)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // compare tasks.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic fail_run(input string what);
        $display("%s", what);
        $display("Result: FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_word(input string name, input logic [xlen-1:0] got,
                              input logic [xlen-1:0] exp);
        if (got !== exp) begin
            fail_run($sformatf("FAIL t=%0t %s got %08h expected %08h", $time, name, got, exp));
        end
    endtask

    task automatic check_excp(input string name, input excp_e got, input excp_e exp);
        if (got !== exp) begin
            fail_run($sformatf("FAIL t=%0t %s got %02h expected %02h", $time, name, got, exp));
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            fail_run($sformatf("FAIL t=%0t %s got %b expected %b", $time, name, got, exp));
        end
    endtask

    // memory word that holds a byte address, wrapping at the top.
    function automatic int word_index(input logic [xlen-1:0] pc);
        return int'((pc >> 2) % mem_words);
    endfunction

    task automatic check_pop();
        logic [xlen-1:0] exp_inst0;
        logic [xlen-1:0] exp_inst1;
        excp_e           exp_excp;
        if (exp_pc[1:0] != 2'b00) begin
            // address fault, nothing read behind it.
            exp_inst0 = inst_nop;
            exp_inst1 = inst_nop;
            exp_excp  = excp_adef;
        end else begin
            exp_inst0 = shadow[word_index(exp_pc)];
            exp_inst1 = shadow[word_index(exp_pc + 4)];
            exp_excp  = excp_none;
        end
        check_word("fifo_pc", fifo_pc, exp_pc);
        check_word("fifo_pc_add", fifo_pc_add, exp_pc + 4);
        check_word("fifo_pc_next", fifo_pc_next, exp_pc + 8);
        check_word("fifo_inst0", fifo_inst0, exp_inst0);
        check_word("fifo_inst1", fifo_inst1, exp_inst1);
        check_excp("fifo_exception", fifo_exception, exp_excp);
        exp_pc    = exp_pc + 8;
        pop_count = pop_count + 1;
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stimulus helpers, inputs change 2 ns after the rising edge.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic do_redirect(input logic [xlen-1:0] pc);
        next_cycle();
        redirect    = 1'b1;
        redirect_pc = pc;
        next_cycle();
        redirect    = 1'b0;
    endtask

    // decode takes n bundles, then stops taking.
    task automatic pop_bundles(input int n, input logic random_ready);
        int target;
        target = pop_count + n;
        while (pop_count < target) begin
            fifo_ready = random_ready ? ($urandom_range(0, 1) == 1) : 1'b1;
            next_cycle();
        end
        fifo_ready = 1'b0;
    endtask

    // sample in mid cycle, where every output has settled.
    always @(negedge clk) begin
        if (arst_n) begin
            check_bit("ld_busy", ld_busy, ld_we);
            if (ld_we) begin
                shadow[ld_addr] = ld_wdata;
            end
            if (redirect) begin
                exp_pc   = redirect_pc;
                model_on = 1'b1;
            end else if (model_on && fifo_valid && fifo_ready) begin
                check_pop();
            end
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= max_cycles) begin
            fail_run("timeout, the sequence did not finish within the cycle limit");
        end
    end

    initial begin : main_seq
        int              i;
        int              start;
        int              held;
        int              waddr;
        logic [xlen-1:0] target;
        ld_we       = 1'b0;
        ld_addr     = '0;
        ld_wdata    = '0;
        redirect    = 1'b0;
        redirect_pc = '0;
        fifo_ready  = 1'b0;
        model_on    = 1'b0;
        pop_count   = 0;
        void'($urandom(32'h296f));

        // reset state, first falling edge inside reset.
        @(posedge clk);
        @(negedge clk);
        check_bit("fifo_valid", fifo_valid, 1'b0);
        check_bit("ld_busy", ld_busy, 1'b0);
        check_word("fifo_inst0", fifo_inst0, inst_nop);
        check_word("fifo_inst1", fifo_inst1, inst_nop);
        check_word("fifo_pc", fifo_pc, pc_reset);
        @(posedge arst_n);
        @(negedge clk);
        check_bit("fifo_valid", fifo_valid, 1'b0);
        check_bit("ld_busy", ld_busy, 1'b0);

        // preload every word, the loader keeps fetch off the port.
        for (i = 0; i < mem_words; i++) begin
            next_cycle();
            ld_we    = 1'b1;
            ld_addr  = i[imem_addr_w-1:0];
            ld_wdata = $urandom();
        end
        next_cycle();
        ld_we = 1'b0;

        // sequential run, decode always ready.
        do_redirect(pc_reset);
        start = cycles;
        pop_bundles(40, 1'b0);
        if (cycles - start > 2 * 40 + 8) begin
            fail_run("sequential fetch slower than one bundle every two cycles");
        end

        // back-pressure.
        pop_bundles(1200, 1'b1);

        // aligned redirects, with the buffer full behind a stalled decode.
        for (i = 0; i < 8; i++) begin
            pop_bundles($urandom_range(1, 6), 1'b1);
            repeat (4) next_cycle();
            target = $urandom_range(0, mem_words - 1) << 2;
            do_redirect(target);
            pop_bundles(6, 1'b1);
        end

        // misaligned target.
        target = ($urandom_range(0, mem_words - 1) << 2) | $urandom_range(1, 3);
        do_redirect(target);
        pop_bundles(1, 1'b0);
        held       = pop_count;
        fifo_ready = 1'b1;
        repeat (20) next_cycle();
        fifo_ready = 1'b0;
        if (pop_count != held) begin
            fail_run("fetch went on after an address fault");
        end

        // patch the upper half while fetch runs low, then jump into it.
        // decode keeps popping, so fetch requests compete with the writes.
        do_redirect(pc_reset);
        fork
            pop_bundles(24, 1'b1);
            begin
                for (i = 0; i < 24; i++) begin
                    waddr = mem_words / 2 + $urandom_range(0, 31);
                    next_cycle();
                    ld_we    = 1'b1;
                    ld_addr  = waddr[imem_addr_w-1:0];
                    ld_wdata = $urandom();
                    next_cycle();
                    ld_we = 1'b0;
                    repeat ($urandom_range(0, 2)) next_cycle();
                end
            end
        join
        do_redirect((mem_words / 2) * 4);
        pop_bundles(16, 1'b1);

        repeat (4) next_cycle();
        $display("Result: PASSED");
        $finish;
    end

endmodule

// File: filelist.f
fetch_pkg.sv
inst_mem.sv
imem_arbiter.sv
fetch_pc_gen.sv
fetch_buf_fifo.sv
fetch_buffer.sv
fetch_frontend_top.sv
tb_clk_gen.sv
tb_fetch_frontend.sv

// File: Bender.yml
package:
  name: fetch_frontend

sources:
  - fetch_pkg.sv
  - inst_mem.sv
  - imem_arbiter.sv
  - fetch_pc_gen.sv
  - fetch_buf_fifo.sv
  - fetch_buffer.sv
  - fetch_frontend_top.sv
  - target: test
    files:
      - tb_clk_gen.sv
      - tb_fetch_frontend.sv
